//--- edge_job_control.f
+incdir+source
source/mem_cmd_pkg.sv
source/graph_job_pkg.sv
source/edge_job_if.sv
source/sync_fifo.sv
source/edge_job_registers.sv
source/edge_read_sequencer.sv
source/edge_line_shifter.sv
source/edge_job_control.sv
testbench/edge_job_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the edge job control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module edge_job_control_tb \
	-f edge_job_control.f -o edge_job_control_sim

output=$(./obj_dir/edge_job_control_sim || true)
echo "$output"
echo "$output" | grep -q "SIMULATION PASSED"

//--- source/edge_job_cfg.svh
// Width, line geometry and queue depth macros for the edge job control unit
`ifndef EDGE_JOB_CFG_SVH
`define EDGE_JOB_CFG_SVH

// One inverse edge array entry
`define EDGE_BITS 32

// Cache line geometry
`define LINE_BYTES 64
`define LINE_EDGES 16
`define LINE_BITS 512
// Edge position within a line, and edge count 1..16
`define LINE_OFFSET_BITS 4
`define LINE_COUNT_BITS 5

// Address and vertex fields
`define ADDR_BITS 32
`define DEGREE_BITS 16
`define EDGE_INDEX_BITS 16
`define VERTEX_BITS 32

// Queue depths
`define CMD_QUEUE_DEPTH 16
`define EDGE_QUEUE_DEPTH 32

`endif

//--- source/edge_job_control.sv
// Top level of the edge job control unit: register block, datapath and queues
`timescale 1ns/1ps
`include "edge_job_cfg.svh"

module edge_job_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,
	input  logic [`ADDR_BITS-1:0]        array_base,
	input  logic                         vertex_valid,
	input  logic [`VERTEX_BITS-1:0]      vertex_id,
	input  logic [`EDGE_INDEX_BITS-1:0]  vertex_edge_index,
	input  logic [`DEGREE_BITS-1:0]      vertex_degree,
	output logic                         vertex_taken,
	output logic                         cmd_request,
	output logic [`ADDR_BITS-1:0]        cmd_address,
	output logic [`LINE_OFFSET_BITS-1:0] cmd_offset,
	output logic [`LINE_COUNT_BITS-1:0]  cmd_count,
	output logic                         cmd_kind,
	input  logic                         cmd_grant,
	input  logic                         line_valid,
	input  logic [`LINE_BITS-1:0]        line_data,
	input  logic [`LINE_OFFSET_BITS-1:0] line_offset,
	input  logic [`LINE_COUNT_BITS-1:0]  line_count,
	output logic                         edge_valid,
	output logic [`VERTEX_BITS-1:0]      edge_src,
	output logic [`VERTEX_BITS-1:0]      edge_dest,
	output logic [`DEGREE_BITS-1:0]      edge_serial,
	input  logic                         edge_request
);

	mem_cmd_pkg::read_cmd_t   cmd_word;
	mem_cmd_pkg::read_cmd_t   cmd_head;
	graph_job_pkg::edge_job_t edge_word;
	graph_job_pkg::edge_job_t edge_head;
	logic                     cmd_push;
	logic                     cmd_empty;
	logic                     edge_push;
	logic                     edge_empty;
	logic                     edge_almost_full;
	logic                     line_done;

	edge_job_if cfg_bus ();

	edge_job_registers i_edge_job_registers (
		.clock(clock), .rstn(rstn), .enable(enable), .array_base(array_base),
		.vertex_valid(vertex_valid), .vertex_id(vertex_id),
		.vertex_edge_index(vertex_edge_index), .vertex_degree(vertex_degree),
		.vertex_taken(vertex_taken), .cfg(cfg_bus.registers)
	);

	edge_read_sequencer i_edge_read_sequencer (
		.clock(clock), .rstn(rstn), .cfg(cfg_bus.sequencer),
		.cmd_push(cmd_push), .cmd_word(cmd_word), .cmd_empty(cmd_empty),
		.edge_empty(edge_empty), .line_done(line_done)
	);

	edge_line_shifter i_edge_line_shifter (
		.clock(clock), .rstn(rstn), .cfg(cfg_bus.shifter),
		.line_valid(line_valid), .line_data(line_data), .line_offset(line_offset),
		.line_count(line_count), .edge_push(edge_push), .edge_word(edge_word),
		.edge_almost_full(edge_almost_full), .line_done(line_done)
	);

	// Command queue, popped by the memory port grant
	sync_fifo #(.width($bits(mem_cmd_pkg::read_cmd_t)), .depth(`CMD_QUEUE_DEPTH)) i_cmd_queue (
		.clock(clock), .rstn(rstn), .push(cmd_push), .data_in(cmd_word), .pop(cmd_grant),
		.data_out(cmd_head), .empty(cmd_empty), .almost_full(), .full()
	);

	// Edge queue, popped by requests while an edge is shown
	sync_fifo #(.width($bits(graph_job_pkg::edge_job_t)), .depth(`EDGE_QUEUE_DEPTH)) i_edge_queue (
		.clock(clock), .rstn(rstn), .push(edge_push), .data_in(edge_word),
		.pop(edge_request && !edge_empty), .data_out(edge_head), .empty(edge_empty),
		.almost_full(edge_almost_full), .full()
	);

	assign cmd_request = !cmd_empty;
	assign cmd_address = cmd_head.address;
	assign cmd_offset  = cmd_head.offset;
	assign cmd_count   = cmd_head.count;
	assign cmd_kind    = cmd_head.kind;

	assign edge_valid  = !edge_empty;
	assign edge_src    = edge_head.src;
	assign edge_dest   = edge_head.dest;
	assign edge_serial = edge_head.serial;

endmodule

//--- source/edge_job_if.sv
// Interface for the latched job configuration between register block and datapath
`timescale 1ns/1ps
`include "edge_job_cfg.svh"

interface edge_job_if;

	// From the register block
	logic                      enabled;
	logic [`ADDR_BITS-1:0]     array_base;
	graph_job_pkg::vertex_job_t vertex;
	logic                      vertex_new;

	// From the sequencer, high while idle
	logic vertex_done;

	modport registers (
		output enabled,
		output array_base,
		output vertex,
		output vertex_new,
		input  vertex_done
	);

	modport sequencer (
		input  enabled,
		input  array_base,
		input  vertex,
		input  vertex_new,
		output vertex_done
	);

	// Serial numbers restart on vertex_new
	modport shifter (
		input enabled,
		input vertex,
		input vertex_new
	);

endinterface

//--- source/edge_job_registers.sv
// Enable, base address and vertex job registers with new-vertex detection
`timescale 1ns/1ps
`include "edge_job_cfg.svh"

module edge_job_registers (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enable,
	input  logic [`ADDR_BITS-1:0]       array_base,
	input  logic                        vertex_valid,
	input  logic [`VERTEX_BITS-1:0]     vertex_id,
	input  logic [`EDGE_INDEX_BITS-1:0] vertex_edge_index,
	input  logic [`DEGREE_BITS-1:0]     vertex_degree,
	output logic                        vertex_taken,
	edge_job_if.registers               cfg
);

	logic have_vertex;
	logic id_is_new;
	logic accept;

	// Same id as the last vertex means it was already processed
	assign id_is_new = !have_vertex || (vertex_id != cfg.vertex.id);
	assign accept    = cfg.enabled && vertex_valid && cfg.vertex_done && !cfg.vertex_new &&
		id_is_new;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg.enabled    <= 1'b0;
			cfg.vertex_new <= 1'b0;
			vertex_taken   <= 1'b0;
			have_vertex    <= 1'b0;
		end else begin
			cfg.enabled    <= enable;
			cfg.vertex_new <= accept;
			vertex_taken   <= accept;
			if (accept) begin
				have_vertex <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		cfg.array_base <= array_base;
		if (accept) begin
			cfg.vertex.id         <= vertex_id;
			cfg.vertex.edge_index <= vertex_edge_index;
			cfg.vertex.degree     <= vertex_degree;
		end
	end

endmodule

//--- source/edge_line_shifter.sv
// Captures returned data lines and shifts the selected edges out as edge jobs
`timescale 1ns/1ps
`include "edge_job_cfg.svh"

module edge_line_shifter (
	input  logic                         clock,
	input  logic                         rstn,
	edge_job_if.shifter                  cfg,
	input  logic                         line_valid,
	input  mem_cmd_pkg::line_word_t      line_data,
	input  logic [`LINE_OFFSET_BITS-1:0] line_offset,
	input  logic [`LINE_COUNT_BITS-1:0]  line_count,
	output logic                         edge_push,
	output graph_job_pkg::edge_job_t     edge_word,
	input  logic                         edge_almost_full,
	output logic                         line_done
);

	mem_cmd_pkg::line_word_t     line_reg;
	logic [`LINE_COUNT_BITS-1:0] left;
	logic [`DEGREE_BITS-1:0]     serial;

	////////////////////////////////////////////////////////////
	// Line register
	////////////////////////////////////////////////////////////

	// Skip the leading entries on capture, then entry 0 is always the next edge
	always_ff @(posedge clock) begin
		if (line_valid) begin
			line_reg.raw <= line_data.raw >> (line_offset * `EDGE_BITS);
		end else if (edge_push) begin
			line_reg.raw <= line_reg.raw >> `EDGE_BITS;
		end
	end

	////////////////////////////////////////////////////////////
	// Edge emission
	////////////////////////////////////////////////////////////

	// One edge per cycle while the edge queue has room
	assign edge_push = (left != '0) && cfg.enabled && !edge_almost_full;

	assign edge_word.src    = cfg.vertex.id;
	assign edge_word.dest   = line_reg.entry[0];
	assign edge_word.serial = serial;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			left      <= '0;
			serial    <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= edge_push && (left == 1);
			if (line_valid) begin
				left <= line_count;
			end else if (edge_push) begin
				left <= left - 1'b1;
			end
			if (cfg.vertex_new) begin
				serial <= '0;
			end else if (edge_push) begin
				serial <= serial + 1'b1;
			end
		end
	end

	a_line_fits: assert property (
		@(posedge clock) disable iff (!rstn)
		line_valid |-> (line_offset + line_count <= `LINE_EDGES)
	);

	// Only one command outstanding, so a line never lands on a busy shifter
	a_one_line: assert property (
		@(posedge clock) disable iff (!rstn)
		line_valid |-> (left == '0)
	);

endmodule

//--- source/edge_read_sequencer.sv
// FSM that cuts a vertex's edge range into cache line read commands
`timescale 1ns/1ps
`include "edge_job_cfg.svh"

module edge_read_sequencer (
	input  logic                  clock,
	input  logic                  rstn,
	edge_job_if.sequencer         cfg,
	output logic                  cmd_push,
	output mem_cmd_pkg::read_cmd_t cmd_word,
	input  logic                  cmd_empty,
	input  logic                  edge_empty,
	input  logic                  line_done
);

	localparam int line_lsb = $clog2(`LINE_BYTES);
	localparam int edge_lsb = $clog2(`EDGE_BITS / 8);

	typedef enum logic [1:0] {
		seq_idle,
		seq_issue,
		seq_wait
	} seq_state_t;

	seq_state_t                  state;
	logic [`DEGREE_BITS-1:0]     remaining;
	logic [`ADDR_BITS-1:0]       byte_offset;
	logic [`ADDR_BITS-1:0]       aligned_offset;
	logic [`LINE_OFFSET_BITS-1:0] line_pos;
	logic [`LINE_COUNT_BITS-1:0]  room;
	logic [`LINE_COUNT_BITS-1:0]  count;
	logic                        last;

	////////////////////////////////////////////////////////////
	// Command fields for the current position
	////////////////////////////////////////////////////////////

	assign aligned_offset = {byte_offset[`ADDR_BITS-1:line_lsb], {line_lsb{1'b0}}};
	assign line_pos       = byte_offset[line_lsb-1:edge_lsb];
	// Edges from line_pos to the end of the line
	assign room           = `LINE_COUNT_BITS'(`LINE_EDGES) - line_pos;
	assign last           = remaining <= `DEGREE_BITS'(room);
	assign count          = last ? remaining[`LINE_COUNT_BITS-1:0] : room;

	assign cmd_word.address = cfg.array_base + aligned_offset;
	assign cmd_word.offset  = line_pos;
	assign cmd_word.count   = count;
	assign cmd_word.kind    = last ? mem_cmd_pkg::read_partial : mem_cmd_pkg::read_full;

	// Both queues drained before each new command
	assign cmd_push = (state == seq_issue) && cfg.enabled && cmd_empty && edge_empty;

	assign cfg.vertex_done = (state == seq_idle);

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= seq_idle;
			remaining <= '0;
		end else begin
			case (state)
				seq_idle: begin
					if (cfg.vertex_new) begin
						remaining <= cfg.vertex.degree;
						// Zero degree finishes on the spot
						if (cfg.vertex.degree != '0) begin
							state <= seq_issue;
						end
					end
				end
				seq_issue: begin
					if (cmd_push) begin
						remaining <= remaining - `DEGREE_BITS'(count);
						state     <= seq_wait;
					end
				end
				seq_wait: begin
					if (line_done) begin
						state <= (remaining != '0) ? seq_issue : seq_idle;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	// Byte offset into the inverse edge array
	always_ff @(posedge clock) begin
		if (state == seq_idle && cfg.vertex_new) begin
			byte_offset <= `ADDR_BITS'(cfg.vertex.edge_index) << edge_lsb;
		end else if (cmd_push) begin
			byte_offset <= aligned_offset + `ADDR_BITS'(`LINE_BYTES);
		end
	end

	a_count_range: assert property (
		@(posedge clock) disable iff (!rstn)
		cmd_push |-> (cmd_word.count >= 1 && cmd_word.count <= `LINE_EDGES)
	);

endmodule

//--- source/graph_job_pkg.sv
// Graph-side types: vertex job and edge job
`include "edge_job_cfg.svh"

package graph_job_pkg;

	// Vertex as handed to the unit
	typedef struct packed {
		logic [`VERTEX_BITS-1:0]     id;
		logic [`EDGE_INDEX_BITS-1:0] edge_index;
		logic [`DEGREE_BITS-1:0]     degree;
	} vertex_job_t;

	// One inverse edge of the current vertex
	// Serial counts edges within the vertex, from zero
	typedef struct packed {
		logic [`VERTEX_BITS-1:0] src;
		logic [`VERTEX_BITS-1:0] dest;
		logic [`DEGREE_BITS-1:0] serial;
	} edge_job_t;

endpackage

//--- source/mem_cmd_pkg.sv
// Memory-side types: read command kind, read command, returned data line
`include "edge_job_cfg.svh"

package mem_cmd_pkg;

	// Partial marks the command that ends a vertex
	typedef enum logic {
		read_full    = 1'b0,
		read_partial = 1'b1
	} cmd_kind_t;

	// Line read command for the inverse edge array
	typedef struct packed {
		logic [`ADDR_BITS-1:0]        address;
		logic [`LINE_OFFSET_BITS-1:0] offset;
		logic [`LINE_COUNT_BITS-1:0]  count;
		cmd_kind_t                    kind;
	} read_cmd_t;

	// One returned cache line
	// Entry i holds the edge at byte address line plus 4i
	typedef union packed {
		logic [`LINE_BITS-1:0]                  raw;
		logic [`LINE_EDGES-1:0][`EDGE_BITS-1:0] entry;
	} line_word_t;

endpackage

//--- source/sync_fifo.sv
// First-word-fall-through synchronous FIFO with almost-full flag
`timescale 1ns/1ps

module sync_fifo #(
	parameter int width = 32,
	parameter int depth = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic             empty,
	output logic             almost_full,
	output logic             full
);

	localparam int ptr_bits = $clog2(depth);
	localparam int slack    = 4;

	logic [width-1:0]    mem [depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits:0]   count;

	assign empty       = (count == '0);
	assign full        = (count == (ptr_bits + 1)'(depth));
	assign almost_full = (count >= (ptr_bits + 1)'(depth - slack));
	// Head is visible without a pop
	assign data_out    = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push && !full) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (ptr_bits + 1)'(push && !full) - (ptr_bits + 1)'(pop && !empty);
		end
	end

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

//--- testbench/edge_job_control_tb.sv
// Clock, reset, LFSR, memory model, reference function, checks and watchdog of the unit's testbench
`timescale 1ns/1ps
`include "edge_job_cfg.svh"

module edge_job_control_tb;

	localparam int clock_half = 20;
	localparam int random_vertices = 12;
	// Directed degrees plus the largest possible random degrees
	localparam int total_edges = 5 + 40 + 23 + 60 + 20 + random_vertices * 63;
	localparam int edge_budget = 24;
	localparam int watchdog_cycles = total_edges * edge_budget + 3000;

	typedef enum {mem_idle, mem_grant, mem_return} mem_phase_t;

	logic                         clock;
	logic                         rstn;
	logic                         enable;
	logic [`ADDR_BITS-1:0]        array_base;
	logic                         vertex_valid;
	logic [`VERTEX_BITS-1:0]      vertex_id;
	logic [`EDGE_INDEX_BITS-1:0]  vertex_edge_index;
	logic [`DEGREE_BITS-1:0]      vertex_degree;
	logic                         vertex_taken;
	logic                         cmd_request;
	logic [`ADDR_BITS-1:0]        cmd_address;
	logic [`LINE_OFFSET_BITS-1:0] cmd_offset;
	logic [`LINE_COUNT_BITS-1:0]  cmd_count;
	logic                         cmd_kind;
	logic                         cmd_grant;
	logic                         line_valid;
	logic [`LINE_BITS-1:0]        line_data;
	logic [`LINE_OFFSET_BITS-1:0] line_offset;
	logic [`LINE_COUNT_BITS-1:0]  line_count;
	logic                         edge_valid;
	logic [`VERTEX_BITS-1:0]      edge_src;
	logic [`VERTEX_BITS-1:0]      edge_dest;
	logic [`DEGREE_BITS-1:0]      edge_serial;
	logic                         edge_request;

	mem_cmd_pkg::read_cmd_t   exp_cmds[$];
	graph_job_pkg::edge_job_t exp_edges[$];
	logic [31:0]              lfsr;
	logic                     hold_requests;
	string                    test_name;

	edge_job_control i_edge_job_control (
		.clock(clock), .rstn(rstn), .enable(enable), .array_base(array_base),
		.vertex_valid(vertex_valid), .vertex_id(vertex_id),
		.vertex_edge_index(vertex_edge_index), .vertex_degree(vertex_degree),
		.vertex_taken(vertex_taken), .cmd_request(cmd_request), .cmd_address(cmd_address),
		.cmd_offset(cmd_offset), .cmd_count(cmd_count), .cmd_kind(cmd_kind),
		.cmd_grant(cmd_grant), .line_valid(line_valid), .line_data(line_data),
		.line_offset(line_offset), .line_count(line_count), .edge_valid(edge_valid),
		.edge_src(edge_src), .edge_dest(edge_dest), .edge_serial(edge_serial),
		.edge_request(edge_request)
	);

	initial clock = 1'b0;
	always #clock_half clock = ~clock;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		logic        out_bit;
		value = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr[0];
			lfsr = {1'b0, lfsr[31:1]} ^ (out_bit ? 32'h8020_0003 : 32'h0);
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	// Expected commands and edges of one vertex
	function automatic void build_expected(input logic [31:0] id, input logic [15:0] index,
		input logic [15:0] degree, input logic [31:0] base);
		mem_cmd_pkg::read_cmd_t   cmd;
		graph_job_pkg::edge_job_t job;
		int offset;
		int line_start;
		int pos;
		int room;
		int count;
		int remaining;
		offset = int'(index) * 4;
		remaining = int'(degree);
		while (remaining > 0) begin
			line_start = offset - offset % `LINE_BYTES;
			pos = (offset % `LINE_BYTES) / 4;
			room = `LINE_EDGES - pos;
			count = (remaining < room) ? remaining : room;
			cmd.address = base + 32'(line_start);
			cmd.offset = 4'(pos);
			cmd.count = 5'(count);
			cmd.kind = (remaining <= room) ? mem_cmd_pkg::read_partial : mem_cmd_pkg::read_full;
			exp_cmds.push_back(cmd);
			offset = line_start + `LINE_BYTES;
			remaining = remaining - count;
		end
		for (int s = 0; s < int'(degree); s++) begin
			job.src = id;
			job.dest = base + 32'(index) * 4 + 32'(s) * 4;
			job.serial = 16'(s);
			exp_edges.push_back(job);
		end
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_equal(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			report_failure($sformatf("Fail %s %s: expected %0h, actual %0h",
				test_name, what, expected, actual));
		end
	endtask

	task automatic offer_vertex(input logic [31:0] id, input logic [15:0] index,
		input logic [15:0] degree);
		vertex_valid      <= 1'b1;
		vertex_id         <= id;
		vertex_edge_index <= index;
		vertex_degree     <= degree;
	endtask

	task automatic await_taken();
		do @(posedge clock); while (!vertex_taken);
		vertex_valid <= 1'b0;
	endtask

	task automatic await_drained();
		while (exp_cmds.size() != 0 || exp_edges.size() != 0) @(posedge clock);
		repeat (3) @(posedge clock);
	endtask

	// Held vertex must stay untouched
	task automatic expect_not_taken(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			assert (!vertex_taken) else report_failure($sformatf("Vertex taken in %s", test_name));
			assert (!cmd_request) else report_failure($sformatf("Command issued in %s", test_name));
		end
	endtask

	task automatic run_vertex(input logic [31:0] id, input logic [15:0] index,
		input logic [15:0] degree);
		build_expected(id, index, degree, array_base);
		offer_vertex(id, index, degree);
		await_taken();
		await_drained();
	endtask

	////////////////////////////////////////////////////////////
	// Memory port model and edge requester
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		mem_cmd_pkg::line_word_t line;
		static mem_phase_t phase = mem_idle;
		static int delay = 0;
		static logic [31:0] granted_address = '0;
		static logic [3:0] granted_offset = '0;
		static logic [4:0] granted_count = '0;
		cmd_grant  <= 1'b0;
		line_valid <= 1'b0;
		if (rstn) begin
			case (phase)
				mem_idle: begin
					if (cmd_request) begin
						delay = int'(random_bits(3));
						phase = mem_grant;
					end
				end
				mem_grant: begin
					if (delay == 0) begin
						cmd_grant <= 1'b1;
						granted_address = cmd_address;
						granted_offset = cmd_offset;
						granted_count = cmd_count;
						delay = 1 + int'(random_bits(2));
						phase = mem_return;
					end else begin
						delay--;
					end
				end
				default: begin
					if (delay == 0) begin
						// Every entry holds its own byte address
						for (int i = 0; i < `LINE_EDGES; i++) begin
							line.entry[i] = granted_address + 32'(i) * 4;
						end
						line_valid  <= 1'b1;
						line_data   <= line.raw;
						line_offset <= granted_offset;
						line_count  <= granted_count;
						phase = mem_idle;
					end else begin
						delay--;
					end
				end
			endcase
		end
	end

	always @(posedge clock) begin
		if (!rstn || hold_requests) begin
			edge_request <= 1'b0;
		end else begin
			edge_request <= (random_bits(2) != 0);
		end
	end

	////////////////////////////////////////////////////////////
	// Compare commands at grant and edges at pop
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		mem_cmd_pkg::read_cmd_t   exp_cmd;
		graph_job_pkg::edge_job_t exp_edge;
		if (rstn && cmd_grant && cmd_request) begin
			assert (exp_cmds.size() != 0) else
				report_failure($sformatf("Unexpected read command in %s", test_name));
			if (exp_cmds.size() != 0) begin
				exp_cmd = exp_cmds.pop_front();
				check_equal("command address", 64'(exp_cmd.address), 64'(cmd_address));
				check_equal("command offset", 64'(exp_cmd.offset), 64'(cmd_offset));
				check_equal("command count", 64'(exp_cmd.count), 64'(cmd_count));
				check_equal("command kind", 64'(exp_cmd.kind), 64'(cmd_kind));
			end
		end
		if (rstn && edge_request && edge_valid) begin
			assert (exp_edges.size() != 0) else
				report_failure($sformatf("Unexpected edge job in %s", test_name));
			if (exp_edges.size() != 0) begin
				exp_edge = exp_edges.pop_front();
				check_equal("edge source", 64'(exp_edge.src), 64'(edge_src));
				check_equal("edge destination", 64'(exp_edge.dest), 64'(edge_dest));
				check_equal("edge serial", 64'(exp_edge.serial), 64'(edge_serial));
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		report_failure("Timeout: the run did not finish within its cycle budget");
	end

	////////////////////////////////////////////////////////////
	// Directed and random vertices
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0]              id;
		graph_job_pkg::edge_job_t held;
		lfsr = 32'hf906;
		hold_requests = 1'b0;
		test_name = "reset";
		rstn = 1'b0;
		enable = 1'b0;
		array_base = '0;
		vertex_valid = 1'b0;
		vertex_id = '0;
		vertex_edge_index = '0;
		vertex_degree = '0;
		cmd_grant = 1'b0;
		line_valid = 1'b0;
		line_data = '0;
		line_offset = '0;
		line_count = '0;
		edge_request = 1'b0;
		repeat (5) @(posedge clock);
		rstn       <= 1'b1;
		enable     <= 1'b1;
		array_base <= 32'h0010_0000;
		@(posedge clock);

		test_name = "aligned";
		run_vertex(32'd11, 16'd32, 16'd5);
		test_name = "misaligned";
		run_vertex(32'd12, 16'd7, 16'd40);
		test_name = "edge content";
		run_vertex(32'd13, 16'd300, 16'd23);

		test_name = "zero degree";
		run_vertex(32'd14, 16'd50, 16'd0);
		repeat (20) begin
			@(posedge clock);
			assert (!cmd_request && !edge_valid) else
				report_failure("Zero degree vertex produced a command or an edge");
		end
		test_name = "repeated id";
		offer_vertex(32'd14, 16'd80, 16'd9);
		expect_not_taken(30);
		vertex_valid <= 1'b0;
		@(posedge clock);

		// Edges pile up in the queue until requests resume
		test_name = "back-pressure";
		hold_requests <= 1'b1;
		build_expected(32'd15, 16'd64, 16'd60, array_base);
		offer_vertex(32'd15, 16'd64, 16'd60);
		await_taken();
		do @(posedge clock); while (!edge_valid);
		repeat (100) @(posedge clock);
		// Nothing popped yet, so the head still shows the first edge
		held = exp_edges[0];
		assert (edge_valid) else
			report_failure("Edge queue ran empty while requests were held back");
		check_equal("held edge destination", 64'(held.dest), 64'(edge_dest));
		check_equal("held edge serial", 64'(held.serial), 64'(edge_serial));
		hold_requests <= 1'b0;
		await_drained();

		test_name = "disable";
		enable <= 1'b0;
		repeat (3) @(posedge clock);
		build_expected(32'd16, 16'd21, 16'd20, array_base);
		offer_vertex(32'd16, 16'd21, 16'd20);
		expect_not_taken(30);
		enable <= 1'b1;
		await_taken();
		await_drained();

		test_name = "random";
		for (int v = 0; v < random_vertices; v++) begin
			array_base <= random_bits(14) << 18;
			@(posedge clock);
			id = 32'd100 + 32'(v) * 8 + random_bits(3);
			run_vertex(id, 16'(random_bits(12)), 16'(random_bits(6)));
		end

		repeat (10) @(posedge clock);
		assert (!cmd_request && !edge_valid) else
			report_failure("Outputs still active after the last vertex");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
